//--- bulls_cows_assert.sv
module bulls_cows_assert (
	input logic                         clk18,
	input logic                         rst,
	input logic                         press,
	input bulls_cows_pkg::game_status_t status
);
	import bulls_cows_pkg::*;

	// counter stops at the limit
	guess_limit: assert property (
		@(posedge clk18) disable iff (!rst)
		status.guesses <= guess_cnt_t'(max_guesses)
	) else $error("guess counter above %0d", max_guesses);

	win_only_done: assert property (
		@(posedge clk18) disable iff (!rst)
		status.win |-> (status.state == st_done)
	) else $error("win flag set outside st_done");

	// fsm acts on the press edge, so the new state is seen one cycle later
	state_after_press: assert property (
		@(posedge clk18) disable iff (!rst)
		!$stable(status.state) |-> $past(press)
	) else $error("state changed without a press");

endmodule

bind game_fsm bulls_cows_assert bulls_cows_assert_i (
	.clk18  (clk18),
	.rst    (rst),
	.press  (press),
	.status (status)
);

//--- bulls_cows_pkg.sv
package bulls_cows_pkg;

	localparam int digit_w          = 4;
	localparam int num_digits       = 4;
	localparam int max_guesses      = 18;
	localparam int debounce_samples = 4;

	// index 3 is the leftmost digit on the board
	typedef logic [num_digits-1:0][digit_w-1:0] code_t;

	typedef logic [2:0] count_t;     // 0..4
	typedef logic [4:0] guess_cnt_t;

	typedef enum logic [1:0] {
		st_set,
		st_hide,
		st_guess,
		st_done
	} game_state_e;

	typedef struct packed {
		count_t a_cnt;  // right digit, right place
		count_t b_cnt;  // right digit, wrong place
	} score_t;

	typedef struct packed {
		game_state_e state;
		score_t      score;
		guess_cnt_t  guesses;
		logic        scored;  // a guess has been scored this round
		logic        win;
	} game_status_t;

	// active low, bit 0 is segment a, bit 6 is segment g
	typedef logic [6:0] seg_t;
	typedef seg_t [7:0] hex_digits_t;

	localparam seg_t seg_blank = 7'h7f;
	localparam seg_t seg_a     = 7'h08;
	localparam seg_t seg_b     = 7'h03;
	localparam seg_t seg_p     = 7'h0c;
	localparam seg_t seg_l     = 7'h47;
	localparam seg_t seg_o     = 7'h40;
	localparam seg_t seg_s     = 7'h12;

	function automatic seg_t hex_to_seg(input logic [digit_w-1:0] value);
		seg_t seg;
		case (value)
			4'h0: seg = 7'h40;
			4'h1: seg = 7'h79;
			4'h2: seg = 7'h24;
			4'h3: seg = 7'h30;
			4'h4: seg = 7'h19;
			4'h5: seg = 7'h12;
			4'h6: seg = 7'h02;  // top bar lit, unlike b
			4'h7: seg = 7'h78;
			4'h8: seg = 7'h00;
			4'h9: seg = 7'h18;
			4'ha: seg = 7'h08;
			4'hb: seg = 7'h03;
			4'hc: seg = 7'h46;
			4'hd: seg = 7'h21;
			4'he: seg = 7'h06;
			4'hf: seg = 7'h0e;
			default: seg = seg_blank;
		endcase
		return seg;
	endfunction

endpackage

//--- bulls_cows_scorer.sv
module bulls_cows_scorer (
	input  bulls_cows_pkg::code_t  guess,
	input  bulls_cows_pkg::code_t  secret,
	output logic                   distinct,
	output bulls_cows_pkg::score_t score
);
	import bulls_cows_pkg::*;

	always_comb begin
		distinct = 1'b1;
		for (int i = 0; i < num_digits; i++) begin
			for (int j = i + 1; j < num_digits; j++) begin
				if (guess[i] == guess[j]) begin
					distinct = 1'b0;
				end
			end
		end
	end

	always_comb begin
		count_t a_sum;
		count_t b_sum;
		logic   hit;
		a_sum = '0;
		b_sum = '0;
		for (int i = 0; i < num_digits; i++) begin
			hit = 1'b0;
			for (int j = 0; j < num_digits; j++) begin
				if (j != i && guess[i] == secret[j]) begin
					hit = 1'b1;
				end
			end
			// at most one per guess digit, so b stays within 0..4
			if (guess[i] == secret[i]) begin
				a_sum = a_sum + 1'b1;
			end else if (hit) begin
				b_sum = b_sum + 1'b1;
			end
		end
		score.a_cnt = a_sum;
		score.b_cnt = b_sum;
	end

endmodule

//--- bulls_cows_top.sv
module bulls_cows_top (
	input  logic                         clk18,
	input  logic                         rst,
	input  bulls_cows_pkg::code_t        sw,
	input  logic                         key,
	output bulls_cows_pkg::game_status_t status,
	output bulls_cows_pkg::hex_digits_t  hex
);
	import bulls_cows_pkg::*;

	logic   press;
	logic   distinct;
	score_t score;
	code_t  secret;

	key_debounce key_debounce_i (
		.clk18 (clk18),
		.rst   (rst),
		.key   (key),
		.press (press)
	);

	// same scorer checks the secret entry and each guess
	bulls_cows_scorer bulls_cows_scorer_i (
		.guess    (sw),
		.secret   (secret),
		.distinct (distinct),
		.score    (score)
	);

	game_fsm game_fsm_i (
		.clk18    (clk18),
		.rst      (rst),
		.press    (press),
		.sw       (sw),
		.distinct (distinct),
		.score    (score),
		.secret   (secret),
		.status   (status)
	);

	seg_display seg_display_i (
		.clk18  (clk18),
		.rst    (rst),
		.status (status),
		.sw     (sw),
		.hex    (hex)
	);

endmodule

//--- game_fsm.sv
module game_fsm (
	input  logic                         clk18,
	input  logic                         rst,
	input  logic                         press,
	input  bulls_cows_pkg::code_t        sw,
	input  logic                         distinct,
	input  bulls_cows_pkg::score_t       score,
	output bulls_cows_pkg::code_t        secret,
	output bulls_cows_pkg::game_status_t status
);
	import bulls_cows_pkg::*;

	logic       sw_zero;
	logic       load_secret;
	logic       clear_secret;
	logic       guess_ok;
	logic       all_bulls;
	guess_cnt_t guesses_nxt;

	assign sw_zero      = (sw == '0);
	assign load_secret  = press && (status.state == st_set) && distinct;
	assign clear_secret = press && (status.state == st_done) && sw_zero;
	assign guess_ok     = press && (status.state == st_guess) && distinct;
	assign all_bulls    = (score.a_cnt == count_t'(num_digits));
	assign guesses_nxt  = status.guesses + 1'b1;

	always_ff @(posedge clk18 or negedge rst) begin
		if (!rst) begin
			secret <= '0;
		end else if (load_secret) begin
			secret <= sw;
		end else if (clear_secret) begin
			secret <= '0;
		end
	end

	always_ff @(posedge clk18 or negedge rst) begin
		if (!rst) begin
			status.state   <= st_set;
			status.score   <= '0;
			status.guesses <= '0;
			status.scored  <= 1'b0;
			status.win     <= 1'b0;
		end else if (press) begin
			case (status.state)
				st_set: begin
					if (distinct) begin
						status.state <= st_hide;
					end
				end
				st_hide: begin
					if (sw_zero) begin  // switches cleared, secret out of sight
						status.state <= st_guess;
					end
				end
				st_guess: begin
					if (guess_ok) begin
						status.score   <= score;
						status.scored  <= 1'b1;
						status.guesses <= guesses_nxt;
						if (all_bulls) begin
							status.state <= st_done;
							status.win   <= 1'b1;
						end else if (guesses_nxt == guess_cnt_t'(max_guesses)) begin
							status.state <= st_done;  // out of guesses
						end
					end
				end
				st_done: begin
					if (clear_secret) begin
						status.state   <= st_set;
						status.score   <= '0;
						status.guesses <= '0;
						status.scored  <= 1'b0;
						status.win     <= 1'b0;
					end
				end
				default: begin
					status.state <= st_set;
				end
			endcase
		end
	end

endmodule

//--- key_debounce.sv
module key_debounce (
	input  logic clk18,
	input  logic rst,
	input  logic key,
	output logic press
);
	import bulls_cows_pkg::*;

	logic                        key_meta;
	logic                        key_sync;
	logic [debounce_samples-1:0] samples;
	logic                        key_level;  // debounced, active low
	logic                        all_low;

	// raw button is asynchronous to clk18
	always_ff @(posedge clk18 or negedge rst) begin
		if (!rst) begin
			key_meta <= 1'b1;
			key_sync <= 1'b1;
		end else begin
			key_meta <= key;
			key_sync <= key_meta;
		end
	end

	always_ff @(posedge clk18 or negedge rst) begin
		if (!rst) begin
			samples <= '1;
		end else begin
			samples <= {samples[debounce_samples-2:0], key_sync};
		end
	end

	assign all_low = ~|samples;

	// level drops only once every sample agrees
	always_ff @(posedge clk18 or negedge rst) begin
		if (!rst) begin
			key_level <= 1'b1;
			press     <= 1'b0;
		end else begin
			key_level <= ~all_low;
			press     <= key_level & all_low;  // one cycle on the fall
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, then search the log for the result

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_bulls_cows -f tb.f -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1

//--- seg_display.sv
module seg_display (
	input  logic                         clk18,
	input  logic                         rst,
	input  bulls_cows_pkg::game_status_t status,
	input  bulls_cows_pkg::code_t        sw,
	output bulls_cows_pkg::hex_digits_t  hex
);
	import bulls_cows_pkg::*;

	hex_digits_t hex_nxt;
	seg_t        sw_seg [num_digits];
	seg_t        a_seg;
	seg_t        b_seg;

	always_comb begin
		for (int i = 0; i < num_digits; i++) begin
			sw_seg[i] = hex_to_seg(sw[i]);
		end
	end

	assign a_seg = hex_to_seg({1'b0, status.score.a_cnt});
	assign b_seg = hex_to_seg({1'b0, status.score.b_cnt});

	always_comb begin
		hex_nxt = {8{seg_blank}};
		case (status.state)
			st_set: begin
				for (int i = 0; i < num_digits; i++) begin
					hex_nxt[i] = sw_seg[i];
				end
			end
			st_guess: begin
				for (int i = 0; i < num_digits; i++) begin
					hex_nxt[i] = sw_seg[i];
				end
				if (status.scored) begin  // nothing to show before the first guess
					hex_nxt[7:4] = {a_seg, seg_a, b_seg, seg_b};
				end
			end
			st_done: begin
				if (status.win) begin
					hex_nxt[3:0] = {seg_p, seg_a, seg_s, seg_s};
				end else begin
					hex_nxt[3:0] = {seg_l, seg_o, seg_s, seg_s};
				end
			end
			default: ;  // st_hide stays dark
		endcase
	end

	always_ff @(posedge clk18 or negedge rst) begin
		if (!rst) begin
			hex <= {8{seg_blank}};
		end else begin
			hex <= hex_nxt;
		end
	end

endmodule

//--- tb.f
bulls_cows_pkg.sv
key_debounce.sv
bulls_cows_scorer.sv
game_fsm.sv
seg_display.sv
bulls_cows_top.sv
bulls_cows_assert.sv
tb_bulls_cows.sv

//--- tb_bulls_cows.sv
module tb_bulls_cows;
	import bulls_cows_pkg::*;

	typedef enum logic [2:0] {
		hx_blank,
		hx_sw,
		hx_score,
		hx_pass,
		hx_loss
	} hex_sel_e;

	typedef struct packed {
		code_t       sw;
		game_state_e state;
		score_t      score;
		guess_cnt_t  guesses;
		logic        win;
		hex_sel_e    sel;
	} entry_t;

	localparam int n_entries      = 12;
	localparam int loss_presses   = 2 + max_guesses;  // secret, hide, guesses
	localparam int timeout_cycles = (n_entries + loss_presses) * 30 + 200;
	localparam code_t loss_secret = 16'h7b2e;

	logic         clk18 = 1'b0;
	logic         rst;
	code_t        sw;
	logic         key;
	game_status_t status;
	hex_digits_t  hex;

	entry_t tbl [n_entries];
	int     errors = 0;
	int     checks = 0;

	bulls_cows_top bulls_cows_top_i (
		.clk18  (clk18),
		.rst    (rst),
		.sw     (sw),
		.key    (key),
		.status (status),
		.hex    (hex)
	);

	always #10 clk18 = ~clk18;

	function automatic entry_t make_entry(input code_t sw_val, input game_state_e st,
			input int a, input int b, input int g, input logic w, input hex_sel_e sel);
		entry_t e;
		e.sw            = sw_val;
		e.state         = st;
		e.score.a_cnt   = count_t'(a);
		e.score.b_cnt   = count_t'(b);
		e.guesses       = guess_cnt_t'(g);
		e.win           = w;
		e.sel           = sel;
		return e;
	endfunction

	// bulls by position, cows as shared digits minus bulls
	function automatic score_t score_guess(input code_t g, input code_t s);
		score_t      r;
		logic [15:0] in_g;
		logic [15:0] in_s;
		int          bulls;
		in_g  = '0;
		in_s  = '0;
		bulls = 0;
		for (int i = 0; i < num_digits; i++) begin
			in_g[g[i]] = 1'b1;
			in_s[s[i]] = 1'b1;
			if (g[i] == s[i]) bulls++;
		end
		r.a_cnt = count_t'(bulls);
		r.b_cnt = count_t'($countones(in_g & in_s) - bulls);
		return r;
	endfunction

	function automatic logic digits_distinct(input code_t g);
		logic [15:0] seen;
		seen = '0;
		for (int i = 0; i < num_digits; i++) begin
			if (seen[g[i]]) return 1'b0;
			seen[g[i]] = 1'b1;
		end
		return 1'b1;
	endfunction

	function automatic code_t random_guess(input code_t avoid);
		code_t g;
		do begin
			g = code_t'($urandom());
		end while (!digits_distinct(g) || g == avoid);
		return g;
	endfunction

	function automatic hex_digits_t expected_hex(input entry_t e);
		hex_digits_t h;
		h = {8{seg_blank}};
		if (e.sel == hx_sw || e.sel == hx_score) begin
			for (int i = 0; i < num_digits; i++) begin
				h[i] = hex_to_seg(e.sw[i]);
			end
		end
		if (e.sel == hx_score) begin
			h[7] = hex_to_seg({1'b0, e.score.a_cnt});
			h[6] = seg_a;
			h[5] = hex_to_seg({1'b0, e.score.b_cnt});
			h[4] = seg_b;
		end
		if (e.sel == hx_pass) h[3:0] = {seg_p, seg_a, seg_s, seg_s};
		if (e.sel == hx_loss) h[3:0] = {seg_l, seg_o, seg_s, seg_s};
		return h;
	endfunction

	task automatic check_status(input entry_t e, input string tag);
		hex_digits_t exp_hex;
		logic        exp_scored;
		exp_hex    = expected_hex(e);
		exp_scored = (e.guesses != '0);  // set by the first scored guess of a round
		checks++;
		assert (status.state == e.state) else begin
			errors++;
			$display("Mismatch at %0t: %s state %0d, expected %0d", $time, tag,
				status.state, e.state);
		end
		assert (status.score == e.score && status.guesses == e.guesses) else begin
			errors++;
			$display("Mismatch at %0t: %s A=%0d B=%0d guesses=%0d, expected %0d %0d %0d",
				$time, tag, status.score.a_cnt, status.score.b_cnt, status.guesses,
				e.score.a_cnt, e.score.b_cnt, e.guesses);
		end
		assert (status.scored == exp_scored) else begin
			errors++;
			$display("Mismatch at %0t: %s scored %b, expected %b", $time, tag,
				status.scored, exp_scored);
		end
		assert (status.win == e.win) else begin
			errors++;
			$display("Mismatch at %0t: %s win %b, expected %b", $time, tag, status.win, e.win);
		end
		assert (hex == exp_hex) else begin
			errors++;
			$display("Mismatch at %0t: %s hex %h, expected %h", $time, tag, hex, exp_hex);
		end
	endtask

	// called 2 units after a rising edge, returns at the same phase
	task automatic press_key(input code_t value);
		sw  = value;
		key = 1'b0;
		repeat (12) @(posedge clk18);
		#2;
		key = 1'b1;
		repeat (15) @(posedge clk18);  // release plus settle
		#2;
	endtask

	task automatic fill_table();
		tbl[0]  = make_entry(16'h1123, st_set, 0, 0, 0, 1'b0, hx_sw);  // repeated digits
		tbl[1]  = make_entry(16'h5a3c, st_hide, 0, 0, 0, 1'b0, hx_blank);
		tbl[2]  = make_entry(16'h0001, st_hide, 0, 0, 0, 1'b0, hx_blank);
		tbl[3]  = make_entry(16'h0000, st_guess, 0, 0, 0, 1'b0, hx_sw);
		tbl[4]  = make_entry(16'h1234, st_guess, 1, 0, 1, 1'b0, hx_score);
		tbl[5]  = make_entry(16'hc35a, st_guess, 0, 4, 2, 1'b0, hx_score);
		tbl[6]  = make_entry(16'h7788, st_guess, 0, 4, 2, 1'b0, hx_score);  // ignored
		tbl[7]  = make_entry(16'h5a3d, st_guess, 3, 0, 3, 1'b0, hx_score);
		tbl[8]  = make_entry(16'h5ac3, st_guess, 2, 2, 4, 1'b0, hx_score);
		tbl[9]  = make_entry(16'h5a3c, st_done, 4, 0, 5, 1'b1, hx_pass);
		tbl[10] = make_entry(16'h0100, st_done, 4, 0, 5, 1'b1, hx_pass);
		tbl[11] = make_entry(16'h0000, st_set, 0, 0, 0, 1'b0, hx_sw);
	endtask

	initial begin
		repeat (timeout_cycles) @(posedge clk18);
		$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		code_t  g;
		score_t sc;
		void'($urandom(32'h98eb_56fc));
		rst = 1'b0;
		sw  = '0;
		key = 1'b1;
		fill_table();
		repeat (3) @(posedge clk18);
		#2;
		check_status(make_entry('0, st_set, 0, 0, 0, 1'b0, hx_blank), "in reset");
		rst = 1'b1;
		repeat (2) @(posedge clk18);
		#2;
		check_status(make_entry('0, st_set, 0, 0, 0, 1'b0, hx_sw), "idle");

		for (int i = 0; i < n_entries; i++) begin
			press_key(tbl[i].sw);
			check_status(tbl[i], $sformatf("entry %0d", i));
		end

		// loss round with random guesses
		press_key(loss_secret);
		check_status(make_entry(loss_secret, st_hide, 0, 0, 0, 1'b0, hx_blank), "loss secret");
		press_key('0);
		check_status(make_entry('0, st_guess, 0, 0, 0, 1'b0, hx_sw), "loss hide");
		for (int k = 1; k <= max_guesses; k++) begin
			g  = random_guess(loss_secret);
			sc = score_guess(g, loss_secret);
			press_key(g);
			if (k == max_guesses) begin
				check_status(make_entry(g, st_done, sc.a_cnt, sc.b_cnt, k, 1'b0, hx_loss),
					$sformatf("loss guess %0d", k));
			end else begin
				check_status(make_entry(g, st_guess, sc.a_cnt, sc.b_cnt, k, 1'b0, hx_score),
					$sformatf("loss guess %0d", k));
			end
		end

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
